// File: redmule_pkg.sv
// Tile size and widths are fixed here; ARRAY_N must be a power of two so row counters wrap cleanly
package redmule_pkg;

  // Tile geometry and element width
  localparam int unsigned ARRAY_N = 4;
  localparam int unsigned ELEM_W  = 16;
  localparam int unsigned DATA_W  = ARRAY_N * ELEM_W;
  localparam int unsigned STEP_W  = $clog2(ARRAY_N);

  localparam int unsigned IN_FIFO_DEPTH = 4;
  localparam int unsigned Z_FIFO_DEPTH  = 2;

  // Peripheral register map, byte addresses
  localparam int unsigned REG_ADDR_W = 8;
  localparam int unsigned REG_W      = 32;

  localparam logic [REG_ADDR_W-1:0] REG_TRIGGER   = 8'h00;
  localparam logic [REG_ADDR_W-1:0] REG_CONFIG    = 8'h04;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 8'h08;
  localparam logic [REG_ADDR_W-1:0] REG_JOB_COUNT = 8'h0C;

  // Scheduler state encoding
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_LOAD    = 2'd1;
  localparam logic [1:0] ST_COMPUTE = 2'd2;
  localparam logic [1:0] ST_STORE   = 2'd3;

  // One matrix row per beat, element 0 in the low bits
  typedef union packed {
    logic [DATA_W-1:0]                  raw;
    logic [ARRAY_N-1:0][ELEM_W-1:0]     elem;
  } beat_u;

endpackage : redmule_pkg

// File: redmule_stream_fifo.sv
// Valid/ready FIFO with no clear input; contents are lost only on reset, pop data is not registered
module redmule_stream_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                push_valid_i,
  output logic                push_ready_o,
  input  redmule_pkg::beat_u  push_data_i,
  output logic                pop_valid_o,
  input  logic                pop_ready_i,
  output redmule_pkg::beat_u  pop_data_o
);
  import redmule_pkg::*;

  beat_u                      mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH):0]     count_q;
  logic                       push_en;
  logic                       pop_en;

  assign push_ready_o = (count_q != ($clog2(DEPTH)+1)'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push_en = push_valid_i && push_ready_o;
  assign pop_en  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == $clog2(DEPTH)'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == $clog2(DEPTH)'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule : redmule_stream_fifo

// File: redmule_ctrl.sv
// Single-job register slave; triggers while busy are dropped and only bit 0 of config is kept
module redmule_ctrl (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_i,
  input  logic                                wen_i,
  input  logic [redmule_pkg::REG_ADDR_W-1:0]  add_i,
  input  logic [redmule_pkg::REG_W-1:0]       data_i,
  output logic                                gnt_o,
  output logic                                r_valid_o,
  output logic [redmule_pkg::REG_W-1:0]       r_data_o,
  input  logic                                done_i,
  output logic                                start_o,
  output logic                                bias_en_o,
  output logic                                busy_o,
  output logic                                evt_o
);
  import redmule_pkg::*;

  logic             rd_en;
  logic             wr_en;
  logic             busy_q;
  logic             start_q;
  logic             evt_q;
  logic             r_valid_q;
  logic             bias_en_q;
  logic [REG_W-1:0] job_count_q;
  logic [REG_W-1:0] r_data_q;

  // Every request is granted at once, wen high means read
  assign gnt_o = req_i;
  assign rd_en = req_i && wen_i;
  assign wr_en = req_i && !wen_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      start_q     <= 1'b0;
      evt_q       <= 1'b0;
      r_valid_q   <= 1'b0;
      bias_en_q   <= 1'b0;
      job_count_q <= '0;
    end else begin
      start_q   <= 1'b0;
      evt_q     <= 1'b0;
      r_valid_q <= rd_en;
      if (wr_en && add_i == REG_CONFIG) begin
        bias_en_q <= data_i[0];
      end
      if (wr_en && add_i == REG_TRIGGER && !busy_q) begin
        start_q <= 1'b1;
        busy_q  <= 1'b1;
      end
      // Job completion
      if (done_i) begin
        busy_q      <= 1'b0;
        evt_q       <= 1'b1;
        job_count_q <= job_count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (add_i)
        REG_CONFIG:    r_data_q <= {{(REG_W-1){1'b0}}, bias_en_q};
        REG_STATUS:    r_data_q <= {{(REG_W-1){1'b0}}, busy_q};
        REG_JOB_COUNT: r_data_q <= job_count_q;
        default:       r_data_q <= '0;
      endcase
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign start_o   = start_q;
  assign bias_en_o = bias_en_q;
  assign busy_o    = busy_q;
  assign evt_o     = evt_q;

endmodule : redmule_ctrl

// File: redmule_scheduler.sv
// One tile per job; clear_o pulses at job start and again on the first compute cycle
module redmule_scheduler (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            start_i,
  input  logic                            bias_en_i,
  input  logic                            x_full_i,
  input  logic                            w_full_i,
  input  logic                            y_full_i,
  input  logic                            store_done_i,
  output logic                            clear_o,
  output logic                            load_x_o,
  output logic                            load_w_o,
  output logic                            load_y_o,
  output logic                            compute_o,
  output logic [redmule_pkg::STEP_W-1:0]  step_o,
  output logic                            store_o,
  output logic                            done_o
);
  import redmule_pkg::*;

  logic [1:0]        state_q;
  logic [STEP_W-1:0] step_q;
  logic              clear_q;
  logic              done_q;
  logic              bias_en_q;
  logic              loaded;

  // Y is only waited for when the job uses a bias
  assign loaded = x_full_i && w_full_i && (y_full_i || !bias_en_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      step_q    <= '0;
      clear_q   <= 1'b0;
      done_q    <= 1'b0;
      bias_en_q <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      done_q  <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q   <= ST_LOAD;
            clear_q   <= 1'b1;
            bias_en_q <= bias_en_i;
          end
        end
        ST_LOAD: begin
          // Flags are stale while the start clear is still high
          if (!clear_q && loaded) begin
            state_q <= ST_COMPUTE;
            clear_q <= 1'b1;
            step_q  <= '0;
          end
        end
        ST_COMPUTE: begin
          // First compute cycle loads the bias, then ARRAY_N steps
          if (!clear_q) begin
            if (step_q == STEP_W'(ARRAY_N-1)) begin
              state_q <= ST_STORE;
              step_q  <= '0;
            end else begin
              step_q <= step_q + 1'b1;
            end
          end
        end
        default: begin
          if (store_done_i) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b1;
          end
        end
      endcase
    end
  end

  assign clear_o   = clear_q;
  assign load_x_o  = (state_q == ST_LOAD);
  assign load_w_o  = (state_q == ST_LOAD);
  assign load_y_o  = (state_q == ST_LOAD) && bias_en_q;
  assign compute_o = (state_q == ST_COMPUTE);
  assign step_o    = step_q;
  assign store_o   = (state_q == ST_STORE);
  assign done_o    = done_q;

endmodule : redmule_scheduler

// File: redmule_x_buffer.sv
// Holds one X tile row by row; rows survive clear, only the fill count restarts
module redmule_x_buffer (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            clear_i,
  input  logic                            load_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  input  redmule_pkg::beat_u              data_i,
  input  logic [redmule_pkg::STEP_W-1:0]  step_i,
  output logic                            full_o,
  output redmule_pkg::beat_u              col_o
);
  import redmule_pkg::*;

  beat_u             mem_q [ARRAY_N];
  logic [STEP_W-1:0] cnt_q;
  logic              full_q;
  logic              accept;

  assign ready_o = load_i && !full_q && !clear_i;
  assign accept  = valid_i && ready_o;
  assign full_o  = full_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else if (accept) begin
      cnt_q  <= cnt_q + 1'b1;
      full_q <= (cnt_q == STEP_W'(ARRAY_N-1));
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[cnt_q] <= data_i;
    end
  end

  // Column k of X, one element from each row
  always_comb begin
    for (int i = 0; i < ARRAY_N; i++) begin
      col_o.elem[i] = mem_q[i].elem[step_i];
    end
  end

endmodule : redmule_x_buffer

// File: redmule_w_buffer.sv
// Holds one W tile row by row; rows survive clear, only the fill count restarts
module redmule_w_buffer (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            clear_i,
  input  logic                            load_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  input  redmule_pkg::beat_u              data_i,
  input  logic [redmule_pkg::STEP_W-1:0]  step_i,
  output logic                            full_o,
  output redmule_pkg::beat_u              row_o
);
  import redmule_pkg::*;

  beat_u             mem_q [ARRAY_N];
  logic [STEP_W-1:0] cnt_q;
  logic              full_q;
  logic              accept;

  assign ready_o = load_i && !full_q && !clear_i;
  assign accept  = valid_i && ready_o;
  assign full_o  = full_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else if (accept) begin
      cnt_q  <= cnt_q + 1'b1;
      full_q <= (cnt_q == STEP_W'(ARRAY_N-1));
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[cnt_q] <= data_i;
    end
  end

  // Row k of W is used whole
  assign row_o = mem_q[step_i];

endmodule : redmule_w_buffer

// File: redmule_z_buffer.sv
// Bias rows read as zero after clear until Y arrives; Z rows leave in order 0 to ARRAY_N-1
module redmule_z_buffer (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          clear_i,
  input  logic                                          load_i,
  input  logic                                          y_valid_i,
  output logic                                          y_ready_o,
  input  redmule_pkg::beat_u                            y_data_i,
  output logic                                          y_full_o,
  output redmule_pkg::beat_u [redmule_pkg::ARRAY_N-1:0] bias_o,
  input  logic                                          store_i,
  input  redmule_pkg::beat_u [redmule_pkg::ARRAY_N-1:0] acc_i,
  output logic                                          z_valid_o,
  input  logic                                          z_ready_i,
  output redmule_pkg::beat_u                            z_data_o,
  output logic                                          store_done_o
);
  import redmule_pkg::*;

  beat_u [ARRAY_N-1:0] bias_q;
  logic [STEP_W-1:0]   y_cnt_q;
  logic [STEP_W-1:0]   z_cnt_q;
  logic                y_full_q;
  logic                y_accept;
  logic                z_accept;

  assign y_ready_o = load_i && !y_full_q && !clear_i;
  assign y_accept  = y_valid_i && y_ready_o;
  assign y_full_o  = y_full_q;
  assign bias_o    = bias_q;

  // Results are stable once compute is over, so rows go out straight from the array
  assign z_valid_o    = store_i;
  assign z_data_o     = acc_i[z_cnt_q];
  assign z_accept     = z_valid_o && z_ready_i;
  assign store_done_o = z_accept && (z_cnt_q == STEP_W'(ARRAY_N-1));

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      y_cnt_q  <= '0;
      z_cnt_q  <= '0;
      y_full_q <= 1'b0;
    end else begin
      if (y_accept) begin
        y_cnt_q  <= y_cnt_q + 1'b1;
        y_full_q <= (y_cnt_q == STEP_W'(ARRAY_N-1));
      end
      if (z_accept) begin
        z_cnt_q <= z_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      bias_q <= '0;
    end else if (y_accept) begin
      bias_q[y_cnt_q] <= y_data_i;
    end
  end

endmodule : redmule_z_buffer

// File: redmule_engine.sv
// Integer multiply-accumulate array; products and sums wrap to ELEM_W bits, clear wins over compute
module redmule_engine (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          clear_i,
  input  logic                                          compute_i,
  input  redmule_pkg::beat_u [redmule_pkg::ARRAY_N-1:0] bias_i,
  input  redmule_pkg::beat_u                            x_col_i,
  input  redmule_pkg::beat_u                            w_row_i,
  output redmule_pkg::beat_u [redmule_pkg::ARRAY_N-1:0] acc_o
);
  import redmule_pkg::*;

  beat_u [ARRAY_N-1:0] acc_q;

  // Step k adds the outer product of X column k and W row k
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= bias_i;
    end else if (compute_i) begin
      for (int i = 0; i < ARRAY_N; i++) begin
        for (int j = 0; j < ARRAY_N; j++) begin
          acc_q[i].elem[j] <= acc_q[i].elem[j] + x_col_i.elem[i] * w_row_i.elem[j];
        end
      end
    end
  end

  assign acc_o = acc_q;

endmodule : redmule_engine

// File: redmule_top.sv
// Single-tile accelerator; X, W and Y arrive as ARRAY_N row beats each, Y is ignored without bias
module redmule_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_i,
  input  logic                                wen_i,
  input  logic [redmule_pkg::REG_ADDR_W-1:0]  add_i,
  input  logic [redmule_pkg::REG_W-1:0]       data_i,
  output logic                                gnt_o,
  output logic                                r_valid_o,
  output logic [redmule_pkg::REG_W-1:0]       r_data_o,
  output logic                                busy_o,
  output logic                                evt_o,
  input  logic                                x_valid_i,
  output logic                                x_ready_o,
  input  redmule_pkg::beat_u                  x_data_i,
  input  logic                                w_valid_i,
  output logic                                w_ready_o,
  input  redmule_pkg::beat_u                  w_data_i,
  input  logic                                y_valid_i,
  output logic                                y_ready_o,
  input  redmule_pkg::beat_u                  y_data_i,
  output logic                                z_valid_o,
  input  logic                                z_ready_i,
  output redmule_pkg::beat_u                  z_data_o
);
  import redmule_pkg::*;

  // FIFO to buffer side of each stream
  logic  x_pop_valid, x_pop_ready;
  logic  w_pop_valid, w_pop_ready;
  logic  y_pop_valid, y_pop_ready;
  logic  z_push_valid, z_push_ready;
  beat_u x_pop_data, w_pop_data, y_pop_data, z_push_data;

  // Controller and scheduler handshake
  logic start, done, bias_en;
  logic clear, load_x, load_w, load_y, compute, store, store_done;
  logic x_full, w_full, y_full;
  logic [STEP_W-1:0] step;

  beat_u               x_col, w_row;
  beat_u [ARRAY_N-1:0] bias, acc;

  redmule_stream_fifo #(
    .DEPTH        ( IN_FIFO_DEPTH )
  ) i_x_fifo (
    .clk_i        ( clk_i         ),
    .reset_i      ( reset_i       ),
    .push_valid_i ( x_valid_i     ),
    .push_ready_o ( x_ready_o     ),
    .push_data_i  ( x_data_i      ),
    .pop_valid_o  ( x_pop_valid   ),
    .pop_ready_i  ( x_pop_ready   ),
    .pop_data_o   ( x_pop_data    )
  );

  redmule_stream_fifo #(
    .DEPTH        ( IN_FIFO_DEPTH )
  ) i_w_fifo (
    .clk_i        ( clk_i         ),
    .reset_i      ( reset_i       ),
    .push_valid_i ( w_valid_i     ),
    .push_ready_o ( w_ready_o     ),
    .push_data_i  ( w_data_i      ),
    .pop_valid_o  ( w_pop_valid   ),
    .pop_ready_i  ( w_pop_ready   ),
    .pop_data_o   ( w_pop_data    )
  );

  redmule_stream_fifo #(
    .DEPTH        ( IN_FIFO_DEPTH )
  ) i_y_fifo (
    .clk_i        ( clk_i         ),
    .reset_i      ( reset_i       ),
    .push_valid_i ( y_valid_i     ),
    .push_ready_o ( y_ready_o     ),
    .push_data_i  ( y_data_i      ),
    .pop_valid_o  ( y_pop_valid   ),
    .pop_ready_i  ( y_pop_ready   ),
    .pop_data_o   ( y_pop_data    )
  );

  redmule_stream_fifo #(
    .DEPTH        ( Z_FIFO_DEPTH  )
  ) i_z_fifo (
    .clk_i        ( clk_i         ),
    .reset_i      ( reset_i       ),
    .push_valid_i ( z_push_valid  ),
    .push_ready_o ( z_push_ready  ),
    .push_data_i  ( z_push_data   ),
    .pop_valid_o  ( z_valid_o     ),
    .pop_ready_i  ( z_ready_i     ),
    .pop_data_o   ( z_data_o      )
  );

  redmule_ctrl i_ctrl (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .req_i     ( req_i     ),
    .wen_i     ( wen_i     ),
    .add_i     ( add_i     ),
    .data_i    ( data_i    ),
    .gnt_o     ( gnt_o     ),
    .r_valid_o ( r_valid_o ),
    .r_data_o  ( r_data_o  ),
    .done_i    ( done      ),
    .start_o   ( start     ),
    .bias_en_o ( bias_en   ),
    .busy_o    ( busy_o    ),
    .evt_o     ( evt_o     )
  );

  redmule_scheduler i_scheduler (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .start_i      ( start      ),
    .bias_en_i    ( bias_en    ),
    .x_full_i     ( x_full     ),
    .w_full_i     ( w_full     ),
    .y_full_i     ( y_full     ),
    .store_done_i ( store_done ),
    .clear_o      ( clear      ),
    .load_x_o     ( load_x     ),
    .load_w_o     ( load_w     ),
    .load_y_o     ( load_y     ),
    .compute_o    ( compute    ),
    .step_o       ( step       ),
    .store_o      ( store      ),
    .done_o       ( done       )
  );

  redmule_x_buffer i_x_buffer (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .clear_i ( clear       ),
    .load_i  ( load_x      ),
    .valid_i ( x_pop_valid ),
    .ready_o ( x_pop_ready ),
    .data_i  ( x_pop_data  ),
    .step_i  ( step        ),
    .full_o  ( x_full      ),
    .col_o   ( x_col       )
  );

  redmule_w_buffer i_w_buffer (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .clear_i ( clear       ),
    .load_i  ( load_w      ),
    .valid_i ( w_pop_valid ),
    .ready_o ( w_pop_ready ),
    .data_i  ( w_pop_data  ),
    .step_i  ( step        ),
    .full_o  ( w_full      ),
    .row_o   ( w_row       )
  );

  redmule_z_buffer i_z_buffer (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .clear_i      ( clear        ),
    .load_i       ( load_y       ),
    .y_valid_i    ( y_pop_valid  ),
    .y_ready_o    ( y_pop_ready  ),
    .y_data_i     ( y_pop_data   ),
    .y_full_o     ( y_full       ),
    .bias_o       ( bias         ),
    .store_i      ( store        ),
    .acc_i        ( acc          ),
    .z_valid_o    ( z_push_valid ),
    .z_ready_i    ( z_push_ready ),
    .z_data_o     ( z_push_data  ),
    .store_done_o ( store_done   )
  );

  redmule_engine i_engine (
    .clk_i     ( clk_i   ),
    .reset_i   ( reset_i ),
    .clear_i   ( clear   ),
    .compute_i ( compute ),
    .bias_i    ( bias    ),
    .x_col_i   ( x_col   ),
    .w_row_i   ( w_row   ),
    .acc_o     ( acc     )
  );

endmodule : redmule_top

// File: redmule_properties.sv
// Watches only top-level outputs and z_ready_i; expects a synchronous active-high reset
module redmule_properties (
  input logic               clk_i,
  input logic               reset_i,
  input logic               busy_i,
  input logic               evt_i,
  input logic               z_valid_i,
  input logic               z_ready_i,
  input redmule_pkg::beat_u z_data_i
);

  // Nothing busy or pending right after a reset cycle
  reset_quiet_a: assert property (@(posedge clk_i) reset_i |=> (!busy_i && !z_valid_i))
    else $error("busy_o or z_valid_o high after reset");

  evt_pulse_a: assert property (@(posedge clk_i) disable iff (reset_i) evt_i |=> !evt_i)
    else $error("evt_o high for two cycles in a row");

  // A stalled Z beat keeps valid and data
  z_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (z_valid_i && !z_ready_i) |=> (z_valid_i && $stable(z_data_i.raw)))
    else $error("z_valid_o or z_data_o changed while z_ready_i was low");

endmodule : redmule_properties

// File: tb_redmule_top.sv
// Runs three single-tile jobs from a fixed seed; Y is streamed only when the job enables the bias
module tb_redmule_top;
  import redmule_pkg::*;

  typedef beat_u [ARRAY_N-1:0] tile_t;

  localparam int unsigned TIMEOUT = 200;
  localparam int unsigned SEL_X   = 0;
  localparam int unsigned SEL_W   = 1;
  localparam int unsigned SEL_Y   = 2;

  logic                  clk_i;
  logic                  reset_i;
  logic                  req_i;
  logic                  wen_i;
  logic [REG_ADDR_W-1:0] add_i;
  logic [REG_W-1:0]      data_i;
  logic                  gnt_o;
  logic                  r_valid_o;
  logic [REG_W-1:0]      r_data_o;
  logic                  busy_o;
  logic                  evt_o;
  logic                  x_valid_i;
  logic                  x_ready_o;
  beat_u                 x_data_i;
  logic                  w_valid_i;
  logic                  w_ready_o;
  beat_u                 w_data_i;
  logic                  y_valid_i;
  logic                  y_ready_o;
  beat_u                 y_data_i;
  logic                  z_valid_o;
  logic                  z_ready_i;
  beat_u                 z_data_o;

  tile_t       exp_z;
  int unsigned z_idx;
  int unsigned evt_count;
  int unsigned errors;
  int unsigned tests;
  int unsigned test_err0;
  string       cur_test;

  redmule_top dut_i (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .req_i     ( req_i     ),
    .wen_i     ( wen_i     ),
    .add_i     ( add_i     ),
    .data_i    ( data_i    ),
    .gnt_o     ( gnt_o     ),
    .r_valid_o ( r_valid_o ),
    .r_data_o  ( r_data_o  ),
    .busy_o    ( busy_o    ),
    .evt_o     ( evt_o     ),
    .x_valid_i ( x_valid_i ),
    .x_ready_o ( x_ready_o ),
    .x_data_i  ( x_data_i  ),
    .w_valid_i ( w_valid_i ),
    .w_ready_o ( w_ready_o ),
    .w_data_i  ( w_data_i  ),
    .y_valid_i ( y_valid_i ),
    .y_ready_o ( y_ready_o ),
    .y_data_i  ( y_data_i  ),
    .z_valid_o ( z_valid_o ),
    .z_ready_i ( z_ready_i ),
    .z_data_o  ( z_data_o  )
  );

  bind redmule_top redmule_properties props_i (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .busy_i    ( busy_o    ),
    .evt_i     ( evt_o     ),
    .z_valid_i ( z_valid_o ),
    .z_ready_i ( z_ready_i ),
    .z_data_i  ( z_data_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Z = X*W (+ Y) with every element wrapped to ELEM_W bits
  function automatic tile_t ref_matmul(input tile_t x, input tile_t w, input tile_t y,
                                       input bit bias);
    tile_t             z;
    logic [ELEM_W-1:0] sum;
    for (int i = 0; i < ARRAY_N; i++) begin
      for (int j = 0; j < ARRAY_N; j++) begin
        sum = bias ? y[i].elem[j] : '0;
        for (int k = 0; k < ARRAY_N; k++) begin
          sum = sum + x[i].elem[k] * w[k].elem[j];
        end
        z[i].elem[j] = sum;
      end
    end
    return z;
  endfunction

  // Compare each accepted Z row against the expected tile
  always @(posedge clk_i) begin
    if (!reset_i && z_valid_o && z_ready_i) begin
      if (z_idx >= ARRAY_N) begin
        errors++;
        $display("%s: a Z row arrived after the last expected row", cur_test);
      end else if (z_data_o.raw !== exp_z[z_idx].raw) begin
        errors++;
        $display("ERR %s row %0d: expected %h, actual %h", cur_test, z_idx,
                 exp_z[z_idx].raw, z_data_o.raw);
      end
      z_idx++;
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i && evt_o) begin
      evt_count++;
    end
  end

  task automatic abort_run(input string what);
    $display("%s: %s", cur_test, what);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic finish_test();
    tests++;
    if (errors == test_err0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - test_err0);
    end
  endtask

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [REG_W-1:0] value);
    req_i  = 1'b1;
    wen_i  = 1'b0;
    add_i  = addr;
    data_i = value;
    @(posedge clk_i);
    if (!gnt_o) begin
      errors++;
      $display("%s: write to address %h was not granted", cur_test, addr);
    end
    #1;
    req_i = 1'b0;
  endtask

  // Response is due exactly one cycle after the grant
  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [REG_W-1:0] value);
    req_i = 1'b1;
    wen_i = 1'b1;
    add_i = addr;
    @(posedge clk_i);
    if (!gnt_o) begin
      errors++;
      $display("%s: read of address %h was not granted", cur_test, addr);
    end
    #1;
    req_i = 1'b0;
    @(posedge clk_i);
    if (!r_valid_o) begin
      errors++;
      $display("%s: no read response one cycle after the grant", cur_test);
    end
    value = r_data_o;
    @(posedge clk_i);
    if (r_valid_o) begin
      errors++;
      $display("%s: read response stayed valid for more than one cycle", cur_test);
    end
    #1;
  endtask

  task automatic drive_stream(input int unsigned sel, input logic valid, input beat_u data);
    case (sel)
      SEL_X: begin
        x_valid_i = valid;
        x_data_i  = data;
      end
      SEL_W: begin
        w_valid_i = valid;
        w_data_i  = data;
      end
      default: begin
        y_valid_i = valid;
        y_data_i  = data;
      end
    endcase
  endtask

  function automatic logic stream_ready(input int unsigned sel);
    case (sel)
      SEL_X:   return x_ready_o;
      SEL_W:   return w_ready_o;
      default: return y_ready_o;
    endcase
  endfunction

  task automatic send_matrix(input int unsigned sel, input tile_t m, input bit gaps);
    int unsigned t;
    int unsigned gap;
    for (int r = 0; r < ARRAY_N; r++) begin
      gap = gaps ? $urandom % 3 : 0;
      // Valid stays low for the length of the gap
      if (gap != 0) begin
        drive_stream(sel, 1'b0, '0);
      end
      repeat (gap) begin
        @(posedge clk_i);
        #1;
      end
      drive_stream(sel, 1'b1, m[r]);
      t = 0;
      @(posedge clk_i);
      while (!stream_ready(sel) && t < TIMEOUT) begin
        t++;
        @(posedge clk_i);
      end
      if (!stream_ready(sel)) begin
        abort_run("an input stream was never accepted before the timeout");
      end
      #1;
    end
    drive_stream(sel, 1'b0, '0);
  endtask

  task automatic collect_z(input bit random_ready);
    int unsigned t;
    t = 0;
    while (z_idx < ARRAY_N && t < TIMEOUT) begin
      z_ready_i = random_ready ? (($urandom % 2) == 1) : 1'b1;
      @(posedge clk_i);
      #1;
      t++;
    end
    z_ready_i = 1'b0;
    if (z_idx < ARRAY_N) begin
      abort_run("fewer Z rows than expected arrived before the timeout");
    end
  endtask

  task automatic wait_idle();
    int unsigned t;
    t = 0;
    while (busy_o && t < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      t++;
    end
    if (busy_o) begin
      abort_run("busy_o stayed high after the last Z row");
    end
  endtask

  task automatic run_job(input string name, input bit bias, input bit stalls);
    tile_t x;
    tile_t w;
    tile_t y;
    start_test(name);
    for (int i = 0; i < ARRAY_N; i++) begin
      for (int j = 0; j < ARRAY_N; j++) begin
        x[i].elem[j] = ELEM_W'($urandom);
        w[i].elem[j] = ELEM_W'($urandom);
        y[i].elem[j] = ELEM_W'($urandom);
      end
    end
    exp_z = ref_matmul(x, w, y, bias);
    z_idx = 0;
    reg_write(REG_CONFIG, REG_W'(bias));
    reg_write(REG_TRIGGER, 32'h1);
    if (!busy_o) begin
      errors++;
      $display("%s: busy_o did not rise the cycle after the trigger write", cur_test);
    end
    // Second trigger lands while busy and has to be dropped
    reg_write(REG_TRIGGER, 32'h1);
    fork
      send_matrix(SEL_X, x, stalls);
      send_matrix(SEL_W, w, stalls);
      if (bias) send_matrix(SEL_Y, y, stalls);
      collect_z(stalls);
    join
    wait_idle();
    finish_test();
  endtask

  initial begin
    logic [REG_W-1:0] rd;
    void'($urandom(32'h2bbe));
    reset_i   = 1'b1;
    req_i     = 1'b0;
    wen_i     = 1'b0;
    add_i     = '0;
    data_i    = '0;
    x_valid_i = 1'b0;
    x_data_i  = '0;
    w_valid_i = 1'b0;
    w_data_i  = '0;
    y_valid_i = 1'b0;
    y_data_i  = '0;
    z_ready_i = 1'b0;
    z_idx     = ARRAY_N;
    evt_count = 0;
    errors    = 0;
    tests     = 0;
    cur_test  = "setup";
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    start_test("reset_values");
    reg_read(REG_STATUS, rd);
    if (rd !== '0) begin
      errors++;
      $display("ERR %s status: expected %h, actual %h", cur_test, 32'h0, rd);
    end
    reg_read(REG_JOB_COUNT, rd);
    if (rd !== '0) begin
      errors++;
      $display("ERR %s job count: expected %h, actual %h", cur_test, 32'h0, rd);
    end
    finish_test();

    run_job("no_bias", 1'b0, 1'b0);
    run_job("with_bias", 1'b1, 1'b0);
    run_job("stalls", 1'b1, 1'b1);

    start_test("job_count");
    reg_read(REG_JOB_COUNT, rd);
    if (rd !== 32'd3) begin
      errors++;
      $display("ERR %s job count: expected %h, actual %h", cur_test, 32'd3, rd);
    end
    if (evt_count != 3) begin
      errors++;
      $display("ERR %s evt pulses: expected %0d, actual %0d", cur_test, 3, evt_count);
    end
    reg_read(REG_STATUS, rd);
    if (rd !== '0) begin
      errors++;
      $display("ERR %s status: expected %h, actual %h", cur_test, 32'h0, rd);
    end
    finish_test();

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_redmule_top

// File: build.f
redmule_pkg.sv
redmule_stream_fifo.sv
redmule_ctrl.sv
redmule_scheduler.sv
redmule_x_buffer.sv
redmule_w_buffer.sv
redmule_z_buffer.sv
redmule_engine.sv
redmule_top.sv
redmule_properties.sv
tb_redmule_top.sv

// File: Bender.yml
package:
  name: redmule_tile

sources:
  - redmule_pkg.sv
  - redmule_stream_fifo.sv
  - redmule_ctrl.sv
  - redmule_scheduler.sv
  - redmule_x_buffer.sv
  - redmule_w_buffer.sv
  - redmule_z_buffer.sv
  - redmule_engine.sv
  - redmule_top.sv
  - target: test
    files:
      - redmule_properties.sv
      - tb_redmule_top.sv
